/* all.f */
source/rv_isa_pkg.sv
source/exec_pkg.sv
source/ex_op_if.sv
source/int_alu.sv
source/branch_agu.sv
source/ex_result_reg.sv
source/rv_execute.sv
bench/ex_checker.sv
bench/tb_rv_execute.sv

/* bench/ex_checker.sv */
// compares the registered execute-stage outputs against the expected table row of the cycle before
`timescale 1ns/1ps
`default_nettype none

module ex_checker #(
    parameter int ROWS = 48
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_row_valid,
    input  int                   i_row_idx,
    input  rv_isa_pkg::xlen_t    i_data,
    input  rv_isa_pkg::reg_idx_t i_rd,
    input  logic                 i_wr_en,
    input  rv_isa_pkg::xlen_t    i_mem_addr,
    input  logic                 i_is_jmp,
    input  rv_isa_pkg::xlen_t    i_jmp_target,
    input  logic                 i_store,
    input  logic                 i_load,
    input  exec_pkg::mem_size_e  i_mem_size,
    input  logic                 i_load_sign_extend,
    input  rv_isa_pkg::xlen_t    i_pc,
    input  rv_isa_pkg::xlen_t    i_exp_data [ROWS],
    input  logic                 i_exp_wr [ROWS],
    input  rv_isa_pkg::reg_idx_t i_exp_rd [ROWS],
    input  logic                 i_exp_jmp [ROWS],
    input  rv_isa_pkg::xlen_t    i_exp_tgt [ROWS],
    input  logic                 i_exp_st [ROWS],
    input  logic                 i_exp_ld [ROWS],
    input  rv_isa_pkg::xlen_t    i_exp_addr [ROWS],
    input  exec_pkg::mem_size_e  i_exp_size [ROWS],
    input  logic                 i_exp_sx [ROWS],
    input  rv_isa_pkg::xlen_t    i_exp_pc [ROWS],
    output int                   o_tests,
    output int                   o_failures
);
    import rv_isa_pkg::*;

    logic row_valid_d;
    int   row_idx_d;

    function automatic int mismatch(input string name, input xlen_t got, input xlen_t exp,
                                    input int row);
        if (got !== exp) begin
            $display("[FAIL] test %0d %s: got 0x%h expected 0x%h", row, name, got, exp);
            return 1;
        end
        return 0;
    endfunction

    // outputs sampled before the edge updates them and the row index lags one cycle
    always @(posedge clk) begin : compare
        int bad;
        int r;
        bad = 0;
        r   = row_idx_d;
        if (reset) begin
            o_tests    <= 0;
            o_failures <= 0;
        end else if (row_valid_d) begin
            bad += mismatch("o_data", i_data, i_exp_data[r], r);
            bad += mismatch("o_wr_en", xlen_t'(i_wr_en), xlen_t'(i_exp_wr[r]), r);
            bad += mismatch("o_rd", xlen_t'(i_rd), xlen_t'(i_exp_rd[r]), r);
            bad += mismatch("o_is_jmp", xlen_t'(i_is_jmp), xlen_t'(i_exp_jmp[r]), r);
            bad += mismatch("o_jmp_target", i_jmp_target, i_exp_tgt[r], r);
            bad += mismatch("o_store", xlen_t'(i_store), xlen_t'(i_exp_st[r]), r);
            bad += mismatch("o_load", xlen_t'(i_load), xlen_t'(i_exp_ld[r]), r);
            bad += mismatch("o_mem_addr", i_mem_addr, i_exp_addr[r], r);
            bad += mismatch("o_mem_size", xlen_t'(i_mem_size), xlen_t'(i_exp_size[r]), r);
            bad += mismatch("o_load_sign_extend", xlen_t'(i_load_sign_extend),
                            xlen_t'(i_exp_sx[r]), r);
            bad += mismatch("o_pc", i_pc, i_exp_pc[r], r);
            if (bad == 0) begin
                $display("test %0d passed", r);
            end else begin
                $display("test %0d failed with %0d mismatches", r, bad);
            end
            o_tests    <= o_tests + 1;
            o_failures <= o_failures + ((bad != 0) ? 1 : 0);
        end
        row_valid_d <= i_row_valid && !reset;
        row_idx_d   <= i_row_idx;
    end

endmodule

`default_nettype wire

/* bench/tb_rv_execute.sv */
// execute-stage testbench that builds the stimulus/expected table and drives one row per cycle
`timescale 1ns/1ps
`default_nettype none

module tb_rv_execute;
    import rv_isa_pkg::*;
    import exec_pkg::*;

    localparam int ROWS = 48;

    logic      clk;
    logic      reset;
    logic      flush;
    opcode_t   opcode;
    xlen_t     rs1_value;
    xlen_t     rs2_value;
    imm12_t    imm12;
    reg_idx_t  rd;
    uimm20_t   uimm;
    xlen_t     pc;
    xlen_t     o_data;
    reg_idx_t  o_rd;
    logic      o_wr_en;
    xlen_t     o_mem_addr;
    logic      o_is_jmp;
    xlen_t     o_jmp_target;
    logic      o_store;
    logic      o_load;
    mem_size_e o_mem_size;
    logic      o_load_sign_extend;
    xlen_t     o_pc;

    // stimulus columns
    opcode_t   t_opc [ROWS];
    xlen_t     t_a [ROWS];
    xlen_t     t_b [ROWS];
    imm12_t    t_imm [ROWS];
    reg_idx_t  t_rd [ROWS];
    uimm20_t   t_uimm [ROWS];
    xlen_t     t_pc [ROWS];
    logic      t_flush [ROWS];
    // expected columns
    xlen_t     e_data [ROWS];
    logic      e_wr [ROWS];
    reg_idx_t  e_rd [ROWS];
    logic      e_jmp [ROWS];
    xlen_t     e_tgt [ROWS];
    logic      e_st [ROWS];
    logic      e_ld [ROWS];
    xlen_t     e_addr [ROWS];
    mem_size_e e_size [ROWS];
    logic      e_sx [ROWS];
    xlen_t     e_pc [ROWS];

    int        n_rows;
    int        cur_idx;
    logic      cur_valid;
    int        tests_done;
    int        failures;

    rv_execute u_rv_execute (
        .clk(clk), .reset(reset), .i_flush(flush), .i_opcode(opcode),
        .i_rs1_value(rs1_value), .i_rs2_value(rs2_value), .i_imm12(imm12),
        .i_rd(rd), .i_uimm(uimm), .i_pc(pc),
        .o_data(o_data), .o_rd(o_rd), .o_wr_en(o_wr_en), .o_mem_addr(o_mem_addr),
        .o_is_jmp(o_is_jmp), .o_jmp_target(o_jmp_target), .o_store(o_store),
        .o_load(o_load), .o_mem_size(o_mem_size),
        .o_load_sign_extend(o_load_sign_extend), .o_pc(o_pc)
    );

    ex_checker #(.ROWS(ROWS)) u_ex_checker (
        .clk(clk), .reset(reset), .i_row_valid(cur_valid), .i_row_idx(cur_idx),
        .i_data(o_data), .i_rd(o_rd), .i_wr_en(o_wr_en), .i_mem_addr(o_mem_addr),
        .i_is_jmp(o_is_jmp), .i_jmp_target(o_jmp_target), .i_store(o_store),
        .i_load(o_load), .i_mem_size(o_mem_size), .i_load_sign_extend(o_load_sign_extend),
        .i_pc(o_pc),
        .i_exp_data(e_data), .i_exp_wr(e_wr), .i_exp_rd(e_rd), .i_exp_jmp(e_jmp),
        .i_exp_tgt(e_tgt), .i_exp_st(e_st), .i_exp_ld(e_ld), .i_exp_addr(e_addr),
        .i_exp_size(e_size), .i_exp_sx(e_sx), .i_exp_pc(e_pc),
        .o_tests(tests_done), .o_failures(failures)
    );

    always #2 clk = ~clk;

    function automatic logic outputs_at_reset_values();
        return (o_wr_en === 1'b0) && (o_rd === 5'd0) && (o_is_jmp === 1'b0)
               && (o_store === 1'b0) && (o_load === 1'b0) && (o_mem_size === SIZE_NONE);
    endfunction

    task automatic add_row(input opcode_t opc, input xlen_t a, input xlen_t b,
                           input imm12_t imm, input reg_idx_t r, input uimm20_t u,
                           input xlen_t p, input logic fl, input xlen_t x_data,
                           input logic x_wr, input logic x_jmp, input xlen_t x_tgt,
                           input logic x_st, input logic x_ld, input xlen_t x_addr,
                           input mem_size_e x_size, input logic x_sx);
        t_opc[n_rows]   = opc;
        t_a[n_rows]     = a;
        t_b[n_rows]     = b;
        t_imm[n_rows]   = imm;
        t_rd[n_rows]    = r;
        t_uimm[n_rows]  = u;
        t_pc[n_rows]    = p;
        t_flush[n_rows] = fl;
        e_data[n_rows]  = x_data;
        e_wr[n_rows]    = x_wr && (r != 0) && !fl;   // x0 and flush never write
        e_rd[n_rows]    = (x_wr && (r != 0) && !fl) ? r : 5'd0;
        e_jmp[n_rows]   = x_jmp && !fl;
        e_tgt[n_rows]   = x_tgt;
        e_st[n_rows]    = x_st && !fl;
        e_ld[n_rows]    = x_ld && !fl;
        e_addr[n_rows]  = x_addr;
        e_size[n_rows]  = x_size;
        e_sx[n_rows]    = x_sx;
        e_pc[n_rows]    = p;
        n_rows++;
    endtask

    task automatic alu_row(input opcode_t opc, input xlen_t a, input xlen_t b,
                           input imm12_t imm, input reg_idx_t r, input logic fl,
                           input xlen_t x_data);
        add_row(opc, a, b, imm, r, 20'h0, 64'h0, fl, x_data, 1'b1, 1'b0, 64'h0,
                1'b0, 1'b0, 64'h0, SIZE_NONE, 1'b0);
    endtask

    // offset +8 encoded through rd[4:1] at pc 0x1000
    task automatic branch_row(input opcode_t opc, input xlen_t a, input xlen_t b,
                              input logic tk);
        add_row(opc, a, b, 12'h000, 5'b01000, 20'h0, 64'h1000, 1'b0,
                tk ? 64'h1004 : 64'h0, 1'b0, tk, tk ? 64'h1008 : 64'h0,
                1'b0, 1'b0, 64'h0, SIZE_NONE, 1'b0);
    endtask

    task automatic build_table;
        xlen_t a;
        xlen_t b;
        a = {$urandom, $urandom};
        b = {$urandom, $urandom};
        alu_row(OP_ADD, a, b, 12'h000, 5'd5, 1'b0, a + b);
        alu_row(OP_ADD, a, b, 12'h400, 5'd6, 1'b0, a - b);
        alu_row(OP_AND, a, b, 12'h000, 5'd7, 1'b0, a & b);
        alu_row(OP_OR, a, b, 12'h000, 5'd8, 1'b0, a | b);
        alu_row(OP_XOR, a, b, 12'h000, 5'd0, 1'b0, a ^ b);   // rd x0
        alu_row(OP_SLT, a, b, 12'h000, 5'd9, 1'b0, {63'b0, $signed(a) < $signed(b)});
        alu_row(OP_SLTU, a, b, 12'h000, 5'd10, 1'b0, {63'b0, a < b});
        alu_row(OP_SLL, a, b, 12'h000, 5'd11, 1'b0, a << b[5:0]);
        alu_row(OP_SRX, a, b, 12'h000, 5'd12, 1'b0, a >> b[5:0]);
        alu_row(OP_SRX, a, b, 12'h400, 5'd13, 1'b0, $signed(a) >>> b[5:0]);
        alu_row(OP_ADDI, a, 64'h0, 12'h801, 5'd14, 1'b0, a - 64'd2047);
        alu_row(OP_SRXI, a, 64'h0, 12'h425, 5'd15, 1'b0, $signed(a) >>> 37);
        alu_row(OP_SLTIU, 64'h5, 64'h0, 12'hfff, 5'd16, 1'b0, 64'h1);
        // word forms
        alu_row(OP_ADDW, 64'h7fffffff, 64'h1, 12'h000, 5'd17, 1'b0, 64'hffffffff80000000);
        alu_row(OP_ADDW, 64'h1234000000000000, 64'h1, 12'h400, 5'd18, 1'b0, '1);
        alu_row(OP_SRXW, 64'h80000000, 64'h4, 12'h400, 5'd19, 1'b0, 64'hfffffffff8000000);
        alu_row(OP_SLLIW, 64'h1, 64'h0, 12'h01f, 5'd20, 1'b0, 64'hffffffff80000000);
        alu_row(OP_ADDIW, 64'h7ffffffe, 64'h0, 12'h001, 5'd21, 1'b0, 64'h7fffffff);
        // branches, taken then not taken
        branch_row(OP_BRANCH_BEQ, a, a, 1'b1);
        branch_row(OP_BRANCH_BEQ, a, a + 1, 1'b0);
        branch_row(OP_BRANCH_BNE, a, a + 1, 1'b1);
        branch_row(OP_BRANCH_BNE, b, b, 1'b0);
        branch_row(OP_BRANCH_BLT, '1, 64'h1, 1'b1);
        branch_row(OP_BRANCH_BLT, 64'h1, '1, 1'b0);
        branch_row(OP_BRANCH_BGE, 64'h1, '1, 1'b1);
        branch_row(OP_BRANCH_BGE, '1, 64'h1, 1'b0);
        branch_row(OP_BRANCH_BLTU, 64'h1, '1, 1'b1);
        branch_row(OP_BRANCH_BLTU, '1, 64'h1, 1'b0);
        branch_row(OP_BRANCH_BGEU, '1, 64'h1, 1'b1);
        branch_row(OP_BRANCH_BGEU, 64'h1, '1, 1'b0);
        // jal targets pc + 2*0x10 and jalr clears bit 0
        add_row(10'h06f, 64'h0, 64'h0, 12'h000, 5'd1, 20'h00010, 64'h2000, 1'b0,
                64'h2004, 1'b1, 1'b1, 64'h2020, 1'b0, 1'b0, 64'h0, SIZE_NONE, 1'b0);
        add_row(OP_JALR, 64'h3001, 64'h0, 12'h004, 5'd2, 20'h0, 64'h100, 1'b0,
                64'h104, 1'b1, 1'b1, 64'h3004, 1'b0, 1'b0, 64'h0, SIZE_NONE, 1'b0);
        // loads and stores
        add_row(OP_LW, 64'h8000, 64'h0, 12'hffc, 5'd7, 20'h0, 64'h0, 1'b0,
                64'h7ffc, 1'b1, 1'b0, 64'h0, 1'b0, 1'b1, 64'h7ffc, SIZE_W, 1'b1);
        add_row(OP_LBU, 64'h100, 64'h0, 12'h003, 5'd8, 20'h0, 64'h0, 1'b0,
                64'h103, 1'b1, 1'b0, 64'h0, 1'b0, 1'b1, 64'h103, SIZE_B, 1'b0);
        add_row(OP_SH, 64'h4000, b, 12'h020, 5'd4, 20'h0, 64'h0, 1'b0,
                {48'h0, b[15:0]}, 1'b0, 1'b0, 64'h0, 1'b1, 1'b0, 64'h4024, SIZE_H, 1'b0);
        add_row(OP_SD, 64'h4000, a, 12'h000, 5'd8, 20'h0, 64'h0, 1'b0,
                a, 1'b0, 1'b0, 64'h0, 1'b1, 1'b0, 64'h4008, SIZE_D, 1'b0);
        // upper immediates
        add_row(10'h037, 64'h0, 64'h0, 12'h000, 5'd3, 20'h80001, 64'h0, 1'b0,
                64'hffffffff80001000, 1'b1, 1'b0, 64'h0, 1'b0, 1'b0, 64'h0, SIZE_NONE, 1'b0);
        add_row(10'h017, 64'h0, 64'h0, 12'h000, 5'd4, 20'h00002, 64'h1000, 1'b0,
                64'h3000, 1'b1, 1'b0, 64'h0, 1'b0, 1'b0, 64'h0, SIZE_NONE, 1'b0);
        // flushed rows keep data but drop the control outputs
        alu_row(OP_ADD, a, b, 12'h000, 5'd5, 1'b1, a + b);
        add_row(10'h06f, 64'h0, 64'h0, 12'h000, 5'd1, 20'h00010, 64'h2000, 1'b1,
                64'h2004, 1'b1, 1'b1, 64'h2020, 1'b0, 1'b0, 64'h0, SIZE_NONE, 1'b0);
        add_row(OP_SD, 64'h4000, a, 12'h000, 5'd8, 20'h0, 64'h0, 1'b1,
                a, 1'b0, 1'b0, 64'h0, 1'b1, 1'b0, 64'h4008, SIZE_D, 1'b0);
    endtask

    initial begin
        int wait_cycles;
        clk       = 1'b0;
        reset     = 1'b1;
        flush     = 1'b0;
        opcode    = '0;
        rs1_value = '0;
        rs2_value = '0;
        imm12     = '0;
        rd        = '0;
        uimm      = '0;
        pc        = '0;
        cur_idx   = 0;
        cur_valid = 1'b0;
        n_rows    = 0;
        void'($urandom(20022));
        build_table();

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // control outputs must sit at their reset values before the first row
        wait_cycles = 0;
        while (!outputs_at_reset_values() && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!outputs_at_reset_values()) begin
            $display("outputs never showed their reset values after reset");
            $display("Test failed");
            $finish;
        end else begin
            for (int i = 0; i < n_rows; i++) begin
                opcode    = t_opc[i];
                rs1_value = t_a[i];
                rs2_value = t_b[i];
                imm12     = t_imm[i];
                rd        = t_rd[i];
                uimm      = t_uimm[i];
                pc        = t_pc[i];
                flush     = t_flush[i];
                cur_idx   = i;
                cur_valid = 1'b1;
                @(negedge clk);
            end
            cur_valid = 1'b0;
            flush     = 1'b0;
            wait_cycles = 0;
            while (tests_done < n_rows && wait_cycles < 20) begin
                @(negedge clk);
                wait_cycles++;
            end
            $display("tests run %0d, passed %0d, failed %0d",
                     tests_done, tests_done - failures, failures);
            if (tests_done == n_rows && failures == 0) begin
                $display("Test completed successfully");
            end else begin
                if (tests_done != n_rows) begin
                    $display("timeout: only %0d of %0d rows were checked", tests_done, n_rows);
                end
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_rv_execute -f all.f -o sim_tb \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
! grep -q "Test failed" sim.log && grep -q "Test completed successfully" sim.log && exit 0 || exit 1

/* source/branch_agu.sv */
// branch and jump resolution plus load/store address, size and store-data generation
`timescale 1ns/1ps
`default_nettype none

module branch_agu (
    ex_op_if.sink                op,
    output logic                 o_taken,
    output rv_isa_pkg::xlen_t    o_target,
    output rv_isa_pkg::xlen_t    o_link,
    output logic                 o_is_load,
    output logic                 o_is_store,
    output rv_isa_pkg::xlen_t    o_mem_addr,
    output rv_isa_pkg::xlen_t    o_store_data,
    output exec_pkg::mem_size_e  o_mem_size,
    output logic                 o_load_sign_extend,
    output logic                 o_writes_rd
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    xlen_t     imm_b;
    xlen_t     imm_j;
    xlen_t     base_sum;
    xlen_t     store_addr;
    logic      eq;
    logic      lt;
    logic      ltu;
    mem_size_e size;

    // B-immediate with its low bits in the rd field
    assign imm_b = {{(XLEN-13){op.imm12[11]}}, op.imm12[11], op.rd[0],
                    op.imm12[10:5], op.rd[4:1], 1'b0};
    assign imm_j = {{(XLEN-21){op.uimm[19]}}, op.uimm, 1'b0};

    assign base_sum   = op.rs1_value + sext12(op.imm12);   // jalr and loads
    assign store_addr = op.rs1_value + sext12({op.imm12[11:5], op.rd});

    assign eq  = (op.rs1_value == op.rs2_value);
    assign lt  = ($signed(op.rs1_value) < $signed(op.rs2_value));
    assign ltu = (op.rs1_value < op.rs2_value);

    assign o_link = op.pc + ILEN_BYTES;

    always_comb begin
        o_taken            = 1'b0;
        o_target           = '0;
        o_is_load          = 1'b0;
        o_is_store         = 1'b0;
        o_mem_addr         = '0;
        o_store_data       = '0;
        o_load_sign_extend = 1'b0;
        o_writes_rd        = 1'b1;
        size               = SIZE_NONE;
        if (op.opcode[6:0] == MAJ_JAL) begin
            o_taken  = 1'b1;
            o_target = op.pc + imm_j;
        end else begin
            case (op.opcode)
                OP_JALR: begin
                    o_taken  = 1'b1;
                    o_target = {base_sum[XLEN-1:1], 1'b0};
                end
                OP_BRANCH_BEQ:  o_taken = eq;
                OP_BRANCH_BNE:  o_taken = !eq;
                OP_BRANCH_BLT:  o_taken = lt;
                OP_BRANCH_BGE:  o_taken = !lt;
                OP_BRANCH_BLTU: o_taken = ltu;
                OP_BRANCH_BGEU: o_taken = !ltu;
                OP_LB, OP_LBU:  size = SIZE_B;
                OP_LH, OP_LHU:  size = SIZE_H;
                OP_LW, OP_LWU:  size = SIZE_W;
                OP_LD:          size = SIZE_D;
                OP_SB:          size = SIZE_B;
                OP_SH:          size = SIZE_H;
                OP_SW:          size = SIZE_W;
                OP_SD:          size = SIZE_D;
                default:        size = SIZE_NONE;
            endcase
        end
        case (op.opcode[6:0])
            MAJ_BRANCH: begin
                o_target    = op.pc + imm_b;
                o_writes_rd = 1'b0;
            end
            MAJ_LOAD: begin
                o_is_load          = (size != SIZE_NONE);
                o_mem_addr         = base_sum;
                o_load_sign_extend = (op.opcode == OP_LB) || (op.opcode == OP_LH)
                                     || (op.opcode == OP_LW);
            end
            MAJ_STORE: begin
                o_is_store   = (size != SIZE_NONE);
                o_mem_addr   = store_addr;
                o_store_data = op.rs2_value & size_mask(size);
                o_writes_rd  = 1'b0;
            end
            default: ;
        endcase
    end

    assign o_mem_size = size;

    // targets stay halfword aligned
    a_target_aligned: assert property (@(posedge op.clk) o_taken |-> !o_target[0]);

endmodule

`default_nettype wire

/* source/ex_op_if.sv */
// one decoded operation, driven from the top-level ports and read by the ALU and the branch/AGU
`timescale 1ns/1ps
`default_nettype none

interface ex_op_if (
    input logic clk
);
    import rv_isa_pkg::*;

    opcode_t  opcode;
    xlen_t    rs1_value;
    xlen_t    rs2_value;
    imm12_t   imm12;      // also carries funct7 for register forms
    reg_idx_t rd;
    uimm20_t  uimm;
    xlen_t    pc;

    modport src (
        output opcode, rs1_value, rs2_value, imm12, rd, uimm, pc
    );

    modport sink (
        input clk, opcode, rs1_value, rs2_value, imm12, rd, uimm, pc
    );

endinterface

`default_nettype wire

/* source/ex_result_reg.sv */
// output register of the execute stage: picks the write-back value and applies flush
`timescale 1ns/1ps
`default_nettype none

module ex_result_reg (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_flush,
    input  rv_isa_pkg::xlen_t    i_alu_result,
    input  logic                 i_alu_valid,
    input  logic                 i_taken,
    input  rv_isa_pkg::xlen_t    i_target,
    input  rv_isa_pkg::xlen_t    i_link,
    input  logic                 i_is_load,
    input  logic                 i_is_store,
    input  rv_isa_pkg::xlen_t    i_mem_addr,
    input  rv_isa_pkg::xlen_t    i_store_data,
    input  exec_pkg::mem_size_e  i_mem_size,
    input  logic                 i_load_sign_extend,
    input  logic                 i_writes_rd,
    input  rv_isa_pkg::reg_idx_t i_rd,
    input  rv_isa_pkg::xlen_t    i_pc,
    output rv_isa_pkg::xlen_t    o_data,
    output rv_isa_pkg::reg_idx_t o_rd,
    output logic                 o_wr_en,
    output rv_isa_pkg::xlen_t    o_mem_addr,
    output logic                 o_is_jmp,
    output rv_isa_pkg::xlen_t    o_jmp_target,
    output logic                 o_store,
    output logic                 o_load,
    output exec_pkg::mem_size_e  o_mem_size,
    output logic                 o_load_sign_extend,
    output rv_isa_pkg::xlen_t    o_pc
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    xlen_t data_next;
    logic  wr_next;

    // a known result that targets a real register
    assign wr_next = i_writes_rd && (i_alu_valid || i_is_load || i_taken)
                     && (i_rd != '0) && !i_flush;

    always_comb begin
        if (i_is_store) begin
            data_next = i_store_data;
        end else if (i_taken) begin
            data_next = i_link;
        end else if (i_is_load) begin
            data_next = i_mem_addr;
        end else begin
            data_next = i_alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_wr_en    <= 1'b0;
            o_rd       <= '0;
            o_is_jmp   <= 1'b0;
            o_store    <= 1'b0;
            o_load     <= 1'b0;
            o_mem_size <= SIZE_NONE;
        end else begin
            o_wr_en    <= wr_next;
            o_rd       <= wr_next ? i_rd : '0;
            o_is_jmp   <= i_taken && !i_flush;
            o_store    <= i_is_store && !i_flush;
            o_load     <= i_is_load && !i_flush;
            o_mem_size <= i_mem_size;
        end
    end

    always_ff @(posedge clk) begin
        o_data             <= data_next;
        o_mem_addr         <= i_mem_addr;
        o_jmp_target       <= i_taken ? i_target : '0;
        o_load_sign_extend <= i_load_sign_extend;
        o_pc               <= i_pc;
    end

    a_flush_no_write: assert property (@(posedge clk) disable iff (reset) i_flush |=> !o_wr_en);

endmodule

`default_nettype wire

/* source/exec_pkg.sv */
// execute-side result types: memory access size, its data mask and the instruction length
`default_nettype none

package exec_pkg;

    typedef enum logic [2:0] {
        SIZE_NONE,
        SIZE_B,
        SIZE_H,
        SIZE_W,
        SIZE_D
    } mem_size_e;

    localparam int unsigned ILEN_BYTES = 4;   // no compressed instructions

    function automatic rv_isa_pkg::xlen_t size_mask(mem_size_e size);
        rv_isa_pkg::xlen_t mask;
        case (size)
            SIZE_B:  mask = 64'h0000_0000_0000_00ff;
            SIZE_H:  mask = 64'h0000_0000_0000_ffff;
            SIZE_W:  mask = 64'h0000_0000_ffff_ffff;
            SIZE_D:  mask = '1;
            default: mask = '0;
        endcase
        return mask;
    endfunction

endpackage

`default_nettype wire

/* source/int_alu.sv */
// integer ALU for RV64I arithmetic, logic, shift, compare, word forms, lui and auipc
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    ex_op_if.sink              op,
    output rv_isa_pkg::xlen_t  o_result,
    output logic               o_alu_valid
);
    import rv_isa_pkg::*;

    xlen_t      a;
    xlen_t      b;
    xlen_t      imm_sx;
    xlen_t      upper_sx;
    xlen_t      sra_res;
    word_t      a_w;
    word_t      sraw_res;
    word_t      w_res;
    xlen_t      res;
    logic [5:0] sh;
    logic [2:0] funct3;
    logic       base_r;
    logic       alt_r;
    logic       alt_i;
    logic       f7_ok;
    logic       valid;

    assign a        = op.rs1_value;
    assign b        = op.rs2_value;
    assign a_w      = a[31:0];
    assign imm_sx   = sext12(op.imm12);
    assign upper_sx = {{(XLEN-32){op.uimm[19]}}, op.uimm, 12'h000};
    assign funct3   = op.opcode[9:7];

    // opcode bit 5 picks register forms over immediate forms
    assign sh       = op.opcode[5] ? b[5:0] : op.imm12[5:0];
    assign sra_res  = $signed(a) >>> sh;
    assign sraw_res = $signed(a_w) >>> sh[4:0];

    assign base_r = (op.imm12[11:5] == FUNCT7_BASE);
    assign alt_r  = (op.imm12[11:5] == FUNCT7_ALT);
    assign alt_i  = (op.imm12[11:6] == FUNCT7_ALT[6:1]);   // shamt[5] sits in bit 0
    // only add/sub and srl/sra accept the alternate funct7
    assign f7_ok  = base_r || (alt_r && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        res   = '0;
        w_res = '0;
        valid = 1'b1;
        if (op.opcode[6:0] == MAJ_LUI) begin
            res = upper_sx;
        end else if (op.opcode[6:0] == MAJ_AUIPC) begin
            res = op.pc + upper_sx;
        end else begin
            case (op.opcode)
                OP_ADDI:  res = a + imm_sx;
                OP_SLTI:  res = xlen_t'($signed(a) < $signed(imm_sx));
                OP_SLTIU: res = xlen_t'(a < imm_sx);
                OP_XORI:  res = a ^ imm_sx;
                OP_ORI:   res = a | imm_sx;
                OP_ANDI:  res = a & imm_sx;
                OP_SLLI:  res = a << sh;
                OP_SRXI:  res = alt_i ? sra_res : a >> sh;
                OP_ADD:   res = alt_r ? a - b : a + b;
                OP_SLL:   res = a << sh;
                OP_SLT:   res = xlen_t'($signed(a) < $signed(b));
                OP_SLTU:  res = xlen_t'(a < b);
                OP_XOR:   res = a ^ b;
                OP_SRX:   res = alt_r ? sra_res : a >> sh;
                OP_OR:    res = a | b;
                OP_AND:   res = a & b;
                OP_ADDIW: w_res = a_w + imm_sx[31:0];
                OP_SLLIW: w_res = a_w << sh[4:0];
                OP_SRXIW: w_res = alt_r ? sraw_res : a_w >> sh[4:0];
                OP_ADDW:  w_res = alt_r ? a_w - b[31:0] : a_w + b[31:0];
                OP_SLLW:  w_res = a_w << sh[4:0];
                OP_SRXW:  w_res = alt_r ? sraw_res : a_w >> sh[4:0];
                default:  valid = 1'b0;
            endcase
            // bit 3 marks the 32-bit opcode groups
            if (op.opcode[3]) begin
                res = {{(XLEN-32){w_res[31]}}, w_res};
            end
            if (op.opcode[5] && !f7_ok) begin
                valid = 1'b0;   // M extension and other funct7 codes
            end
        end
        if (!valid) begin
            res = '0;
        end
    end

    assign o_result    = res;
    assign o_alu_valid = valid;

endmodule

`default_nettype wire

/* source/rv_execute.sv */
// RV64I execute stage top: decoded operands in, registered results out one cycle later
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_flush,
    input  rv_isa_pkg::opcode_t  i_opcode,
    input  rv_isa_pkg::xlen_t    i_rs1_value,
    input  rv_isa_pkg::xlen_t    i_rs2_value,
    input  rv_isa_pkg::imm12_t   i_imm12,
    input  rv_isa_pkg::reg_idx_t i_rd,
    input  rv_isa_pkg::uimm20_t  i_uimm,
    input  rv_isa_pkg::xlen_t    i_pc,
    output rv_isa_pkg::xlen_t    o_data,
    output rv_isa_pkg::reg_idx_t o_rd,
    output logic                 o_wr_en,
    output rv_isa_pkg::xlen_t    o_mem_addr,
    output logic                 o_is_jmp,
    output rv_isa_pkg::xlen_t    o_jmp_target,
    output logic                 o_store,
    output logic                 o_load,
    output exec_pkg::mem_size_e  o_mem_size,
    output logic                 o_load_sign_extend,
    output rv_isa_pkg::xlen_t    o_pc
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    xlen_t     alu_result;
    logic      alu_valid;
    logic      taken;
    xlen_t     target;
    xlen_t     link;
    logic      is_load;
    logic      is_store;
    xlen_t     mem_addr;
    xlen_t     store_data;
    mem_size_e mem_size;
    logic      load_sign_extend;
    logic      writes_rd;

    ex_op_if u_op (.clk(clk));

    assign u_op.opcode    = i_opcode;
    assign u_op.rs1_value = i_rs1_value;
    assign u_op.rs2_value = i_rs2_value;
    assign u_op.imm12     = i_imm12;
    assign u_op.rd        = i_rd;
    assign u_op.uimm      = i_uimm;
    assign u_op.pc        = i_pc;

    int_alu u_int_alu (
        .op          (u_op),
        .o_result    (alu_result),
        .o_alu_valid (alu_valid)
    );

    branch_agu u_branch_agu (
        .op                 (u_op),
        .o_taken            (taken),
        .o_target           (target),
        .o_link             (link),
        .o_is_load          (is_load),
        .o_is_store         (is_store),
        .o_mem_addr         (mem_addr),
        .o_store_data       (store_data),
        .o_mem_size         (mem_size),
        .o_load_sign_extend (load_sign_extend),
        .o_writes_rd        (writes_rd)
    );

    ex_result_reg u_ex_result_reg (
        .clk                (clk),
        .reset              (reset),
        .i_flush            (i_flush),
        .i_alu_result       (alu_result),
        .i_alu_valid        (alu_valid),
        .i_taken            (taken),
        .i_target           (target),
        .i_link             (link),
        .i_is_load          (is_load),
        .i_is_store         (is_store),
        .i_mem_addr         (mem_addr),
        .i_store_data       (store_data),
        .i_mem_size         (mem_size),
        .i_load_sign_extend (load_sign_extend),
        .i_writes_rd        (writes_rd),
        .i_rd               (i_rd),
        .i_pc               (i_pc),
        .o_data             (o_data),
        .o_rd               (o_rd),
        .o_wr_en            (o_wr_en),
        .o_mem_addr         (o_mem_addr),
        .o_is_jmp           (o_is_jmp),
        .o_jmp_target       (o_jmp_target),
        .o_store            (o_store),
        .o_load             (o_load),
        .o_mem_size         (o_mem_size),
        .o_load_sign_extend (o_load_sign_extend),
        .o_pc               (o_pc)
    );

endmodule

`default_nettype wire

/* source/rv_isa_pkg.sv */
// RV64I field types and combined funct3/opcode codes, imported by every execute-stage module
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     word_t;
    typedef logic [11:0]     imm12_t;
    typedef logic [19:0]     uimm20_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [9:0]      opcode_t;   // {funct3, major opcode}
    typedef logic [6:0]      major_t;
    typedef logic [6:0]      funct7_t;

    localparam funct7_t FUNCT7_BASE = 7'b0000000;
    localparam funct7_t FUNCT7_ALT  = 7'b0100000;   // sub, sra

    // major opcodes, funct3 is not part of the match
    localparam major_t MAJ_LUI    = 7'h37;
    localparam major_t MAJ_AUIPC  = 7'h17;
    localparam major_t MAJ_JAL    = 7'h6f;
    localparam major_t MAJ_BRANCH = 7'h63;
    localparam major_t MAJ_LOAD   = 7'h03;
    localparam major_t MAJ_STORE  = 7'h23;

    localparam opcode_t OP_ADDI  = 10'h013;
    localparam opcode_t OP_SLLI  = 10'h093;
    localparam opcode_t OP_SLTI  = 10'h113;
    localparam opcode_t OP_SLTIU = 10'h193;
    localparam opcode_t OP_XORI  = 10'h213;
    localparam opcode_t OP_SRXI  = 10'h293;   // srli and srai
    localparam opcode_t OP_ORI   = 10'h313;
    localparam opcode_t OP_ANDI  = 10'h393;

    localparam opcode_t OP_ADD   = 10'h033;   // add and sub
    localparam opcode_t OP_SLL   = 10'h0b3;
    localparam opcode_t OP_SLT   = 10'h133;
    localparam opcode_t OP_SLTU  = 10'h1b3;
    localparam opcode_t OP_XOR   = 10'h233;
    localparam opcode_t OP_SRX   = 10'h2b3;   // srl and sra
    localparam opcode_t OP_OR    = 10'h333;
    localparam opcode_t OP_AND   = 10'h3b3;

    localparam opcode_t OP_ADDIW = 10'h01b;
    localparam opcode_t OP_SLLIW = 10'h09b;
    localparam opcode_t OP_SRXIW = 10'h29b;
    localparam opcode_t OP_ADDW  = 10'h03b;
    localparam opcode_t OP_SLLW  = 10'h0bb;
    localparam opcode_t OP_SRXW  = 10'h2bb;

    localparam opcode_t OP_JALR        = 10'h067;
    localparam opcode_t OP_BRANCH_BEQ  = 10'h063;
    localparam opcode_t OP_BRANCH_BNE  = 10'h0e3;
    localparam opcode_t OP_BRANCH_BLT  = 10'h263;
    localparam opcode_t OP_BRANCH_BGE  = 10'h2e3;
    localparam opcode_t OP_BRANCH_BLTU = 10'h363;
    localparam opcode_t OP_BRANCH_BGEU = 10'h3e3;

    localparam opcode_t OP_LB  = 10'h003;
    localparam opcode_t OP_LH  = 10'h083;
    localparam opcode_t OP_LW  = 10'h103;
    localparam opcode_t OP_LD  = 10'h183;
    localparam opcode_t OP_LBU = 10'h203;
    localparam opcode_t OP_LHU = 10'h283;
    localparam opcode_t OP_LWU = 10'h303;

    localparam opcode_t OP_SB = 10'h023;
    localparam opcode_t OP_SH = 10'h0a3;
    localparam opcode_t OP_SW = 10'h123;
    localparam opcode_t OP_SD = 10'h1a3;

    function automatic xlen_t sext12(imm12_t value);
        return {{(XLEN-12){value[11]}}, value};
    endfunction

endpackage

`default_nettype wire
